//--- project.f
verilog/mipsPkg.sv
verilog/controller.sv
verilog/pcUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/dataMemory.sv
verilog/mipsCore.sv
verif/mipsCoreTb.sv

//--- verif/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    localparam logic [31:0] resetVector = 32'h0000_0000;
    localparam int dataWords = 256;
    localparam int memBytes = dataWords * 4;
    localparam int romDepth = 64;
    localparam int programLength = 50;
    localparam int cycleLimit = 8 * programLength;
    localparam logic [31:0] haltAddr = 32'd228;

    logic         clk = 1'b0;
    logic         reset;
    instrWord_t   instr;
    logic [31:0]  instrAddr;
    retireTrace_t trace;

    logic [31:0] rom [romDepth];

    // Reference model state
    logic [31:0] modelPc = resetVector;
    logic [31:0] modelRegs [32];
    logic [7:0]  modelMem [memBytes];

    // Prediction for the instruction at modelPc
    logic        expRegWrite;
    logic [4:0]  expWrReg;
    logic [31:0] expWrData;
    logic        expMemWrite;
    logic [31:0] expMemAddr;
    logic [31:0] expStoreData;
    int          expStoreBytes;
    memWidth_t   expStoreWidth;
    logic [31:0] expNextPc;

    int errors = 0;
    int cycles = 0;
    int retired = 0;
    logic halted = 1'b0;
    logic timedOut = 1'b0;

    mipsCore #(.resetVector(resetVector), .dataWords(dataWords)) uut (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .instrAddr(instrAddr),
        .trace    (trace)
    );

    always #2 clk = ~clk;

    // Instruction ROM answers in the same cycle
    assign instr = rom[instrAddr[7:2]];

    function automatic logic [31:0] rType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh, input logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    ////////////////////////////////////////
    // Test program
    ////////////////////////////////////////
    initial begin
        logic [31:0] rnd;
        for (int i = 0; i < romDepth; i++) begin
            rom[i] = '0;
        end
        rnd = $urandom(88);
        // ALU group, some immediates random
        rom[0] = iType(opAddi, 5'd0, 5'd1, 16'd5);
        rom[1] = iType(opAddi, 5'd0, 5'd2, 16'hfffd);
        rnd = $urandom;
        rom[2] = iType(opAddi, 5'd0, 5'd3, rnd[15:0]);
        rnd = $urandom;
        rom[3] = iType(opOri, 5'd0, 5'd4, rnd[15:0]);
        rnd = $urandom;
        // Top immediate bit set so zero extension shows
        rom[4] = iType(opXori, 5'd3, 5'd5, {1'b1, rnd[14:0]});
        rom[5] = iType(opOri, 5'd1, 5'd6, 16'h8001);
        rom[6] = rType(opSpecial, 5'd1, 5'd2, 5'd7, 5'd0, fnAdd);
        rom[7] = rType(opSpecial, 5'd2, 5'd1, 5'd8, 5'd0, fnSub);
        rom[8] = rType(opSpecial, 5'd3, 5'd4, 5'd9, 5'd0, fnAnd);
        rom[9] = rType(opSpecial, 5'd3, 5'd5, 5'd10, 5'd0, fnOr);
        rom[10] = rType(opSpecial, 5'd4, 5'd6, 5'd11, 5'd0, fnXor);
        rom[11] = rType(opSpecial, 5'd2, 5'd1, 5'd12, 5'd0, fnSlt);
        rom[12] = rType(opSpecial, 5'd1, 5'd2, 5'd13, 5'd0, fnSlt);
        rom[13] = iType(opSlti, 5'd2, 5'd14, 16'hffff);
        rom[14] = iType(opSlti, 5'd1, 5'd15, 16'hffff);
        rom[15] = rType(opSpecial, 5'd0, 5'd2, 5'd16, 5'd4, fnSll);
        rom[16] = rType(opSpecial, 5'd0, 5'd2, 5'd17, 5'd28, fnSrl);
        rom[17] = rType(opSpecial2, 5'd2, 5'd8, 5'd18, 5'd0, fnMul);
        rom[18] = rType(opSpecial2, 5'd3, 5'd4, 5'd19, 5'd0, fnMul);
        // r0 ignores the write
        rom[19] = iType(opAddi, 5'd0, 5'd0, 16'd77);
        rom[20] = rType(opSpecial, 5'd0, 5'd1, 5'd20, 5'd0, fnAdd);
        // Stores then loads around address 64
        rom[21] = iType(opAddi, 5'd0, 5'd21, 16'd64);
        rom[22] = iType(opSw, 5'd21, 5'd8, 16'd0);
        rom[23] = iType(opOri, 5'd0, 5'd22, 16'h9234);
        rom[24] = iType(opSh, 5'd21, 5'd22, 16'd6);
        rom[25] = iType(opAddi, 5'd0, 5'd23, 16'h00a5);
        rom[26] = iType(opSb, 5'd21, 5'd23, 16'd9);
        rom[27] = iType(opSb, 5'd21, 5'd1, 16'd2);
        rom[28] = iType(opLw, 5'd21, 5'd24, 16'd0);
        rom[29] = iType(opLh, 5'd21, 5'd25, 16'd6);
        rom[30] = iType(opLb, 5'd21, 5'd26, 16'd9);
        rom[31] = iType(opLh, 5'd21, 5'd27, 16'd0);
        rom[32] = iType(opLw, 5'd21, 5'd28, 16'd8);
        // Each branch kind not taken, then taken over one filler
        rom[33] = iType(opBeq, 5'd1, 5'd2, 16'd1);
        rom[34] = iType(opBeq, 5'd20, 5'd1, 16'd1);
        rom[35] = iType(opAddi, 5'd0, 5'd29, 16'd1);
        rom[36] = iType(opBne, 5'd1, 5'd20, 16'd1);
        rom[37] = iType(opBne, 5'd1, 5'd2, 16'd1);
        rom[38] = iType(opAddi, 5'd0, 5'd29, 16'd2);
        rom[39] = iType(opBgtz, 5'd2, 5'd0, 16'd1);
        rom[40] = iType(opBgtz, 5'd1, 5'd0, 16'd1);
        rom[41] = iType(opAddi, 5'd0, 5'd29, 16'd3);
        rom[42] = iType(opBlez, 5'd1, 5'd0, 16'd1);
        rom[43] = iType(opBlez, 5'd0, 5'd0, 16'd1);
        rom[44] = iType(opAddi, 5'd0, 5'd29, 16'd4);
        rom[45] = iType(opRegimm, 5'd1, 5'd0, 16'd1);
        rom[46] = iType(opRegimm, 5'd2, 5'd0, 16'd1);
        rom[47] = iType(opAddi, 5'd0, 5'd29, 16'd5);
        rom[48] = iType(opRegimm, 5'd2, 5'd1, 16'd1);
        rom[49] = iType(opRegimm, 5'd0, 5'd1, 16'd1);
        rom[50] = iType(opAddi, 5'd0, 5'd29, 16'd6);
        // Call, return, halt
        rom[51] = jType(opJal, 26'd55);
        rom[52] = jType(opJ, 26'd57);
        rom[53] = iType(opAddi, 5'd0, 5'd29, 16'd7);
        rom[54] = iType(opAddi, 5'd0, 5'd29, 16'd8);
        rom[55] = iType(opAddi, 5'd31, 5'd30, 16'd1);
        rom[56] = rType(opSpecial, 5'd31, 5'd0, 5'd0, 5'd0, fnJr);
        rom[57] = jType(opJ, 26'd57);
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic predict();
        logic [31:0] ir;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] rsv;
        logic [31:0] rtv;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] pc4;
        logic [9:0]  a;
        logic        taken;
        ir = rom[modelPc[7:2]];
        op = ir[31:26];
        rs = ir[25:21];
        rt = ir[20:16];
        rd = ir[15:11];
        fn = ir[5:0];
        rsv = modelRegs[rs];
        rtv = modelRegs[rt];
        simm = {{16{ir[15]}}, ir[15:0]};
        zimm = {16'd0, ir[15:0]};
        pc4 = modelPc + 32'd4;
        a = rsv[9:0] + simm[9:0];
        taken = 1'b0;
        expRegWrite = 1'b0;
        expWrReg = rt;
        expWrData = '0;
        expMemWrite = 1'b0;
        expMemAddr = rsv + simm;
        expStoreData = rtv;
        expStoreBytes = 4;
        expStoreWidth = memWord;
        expNextPc = pc4;
        case (op)
            opSpecial: begin
                expRegWrite = 1'b1;
                expWrReg = rd;
                case (fn)
                    fnAdd: expWrData = rsv + rtv;
                    fnSub: expWrData = rsv - rtv;
                    fnAnd: expWrData = rsv & rtv;
                    fnOr:  expWrData = rsv | rtv;
                    fnXor: expWrData = rsv ^ rtv;
                    fnSlt: expWrData = {31'd0, $signed(rsv) < $signed(rtv)};
                    fnSll: expWrData = rtv << ir[10:6];
                    fnSrl: expWrData = rtv >> ir[10:6];
                    fnJr: begin
                        expRegWrite = 1'b0;
                        expNextPc = rsv;
                    end
                    default: expRegWrite = 1'b0;
                endcase
            end
            opSpecial2: begin
                expRegWrite = (fn == fnMul);
                expWrReg = rd;
                expWrData = rsv * rtv;
            end
            opLw, opLh, opLb: begin
                expRegWrite = 1'b1;
                if (op == opLw) begin
                    expWrData = {modelMem[a + 10'd3], modelMem[a + 10'd2],
                                 modelMem[a + 10'd1], modelMem[a]};
                end else if (op == opLh) begin
                    expWrData = {{16{modelMem[a + 10'd1][7]}}, modelMem[a + 10'd1], modelMem[a]};
                end else begin
                    expWrData = {{24{modelMem[a][7]}}, modelMem[a]};
                end
            end
            opSw, opSh, opSb: begin
                expMemWrite = 1'b1;
                if (op == opSw) begin
                    expStoreBytes = 4;
                    expStoreWidth = memWord;
                end else if (op == opSh) begin
                    expStoreBytes = 2;
                    expStoreWidth = memHalf;
                end else begin
                    expStoreBytes = 1;
                    expStoreWidth = memByte;
                end
            end
            opBeq:    taken = (rsv == rtv);
            opBne:    taken = (rsv != rtv);
            opBgtz:   taken = !rsv[31] && rsv != 32'd0;
            opBlez:   taken = rsv[31] || rsv == 32'd0;
            opRegimm: taken = (rt == 5'd0) ? rsv[31] : (rt == 5'd1) ? !rsv[31] : 1'b0;
            opJ, opJal: begin
                expRegWrite = (op == opJal);
                expWrReg = 5'd31;
                expWrData = pc4;
                expNextPc = {pc4[31:28], ir[25:0], 2'b00};
            end
            opOri: begin
                expRegWrite = 1'b1;
                expWrData = rsv | zimm;
            end
            opXori: begin
                expRegWrite = 1'b1;
                expWrData = rsv ^ zimm;
            end
            opSlti: begin
                expRegWrite = 1'b1;
                expWrData = {31'd0, $signed(rsv) < $signed(simm)};
            end
            // addi and anything unknown
            default: begin
                expRegWrite = 1'b1;
                expWrData = rsv + simm;
            end
        endcase
        if (taken) begin
            expNextPc = pc4 + {simm[29:0], 2'b00};
        end
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < memBytes; i++) begin
            modelMem[i] = '0;
        end
    end

    always @(negedge clk) begin
        predict();
    end

    always @(posedge clk) begin
        if (reset) begin
            modelPc <= resetVector;
        end else begin
            modelPc <= expNextPc;
            if (expRegWrite && expWrReg != 5'd0) begin
                modelRegs[expWrReg] <= expWrData;
            end
            if (expMemWrite) begin
                for (int i = 0; i < expStoreBytes; i++) begin
                    modelMem[expMemAddr[9:0] + i[9:0]] <= expStoreData[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic reportFailure(input string what);
        $display("at %0t ns: %s", $time, what);
        errors++;
    endtask

    assert property (@(posedge clk) reset |-> !trace.valid && !trace.regWrite && !trace.memWrite)
        else reportFailure("register or memory write enabled while in reset");

    assert property (@(posedge clk) $fell(reset) |-> trace.pc == resetVector)
        else reportMismatch("trace.pc after reset", resetVector, $sampled(trace.pc));

    assert property (@(posedge clk) !reset |-> trace.valid && trace.pc == modelPc)
        else reportMismatch("trace.pc", $sampled(modelPc), $sampled(trace.pc));

    assert property (@(posedge clk) !reset |-> instrAddr == modelPc)
        else reportMismatch("instrAddr", $sampled(modelPc), $sampled(instrAddr));

    assert property (@(posedge clk) !reset |-> trace.regWrite == expRegWrite)
        else reportMismatch("trace.regWrite", $sampled(expRegWrite), $sampled(trace.regWrite));

    assert property (@(posedge clk) !reset && expRegWrite |-> trace.wrReg == expWrReg)
        else reportMismatch("trace.wrReg", $sampled(expWrReg), $sampled(trace.wrReg));

    assert property (@(posedge clk) !reset && expRegWrite |-> trace.wrData == expWrData)
        else reportMismatch("trace.wrData", $sampled(expWrData), $sampled(trace.wrData));

    assert property (@(posedge clk) !reset |-> trace.memWrite == expMemWrite)
        else reportMismatch("trace.memWrite", $sampled(expMemWrite), $sampled(trace.memWrite));

    assert property (@(posedge clk) !reset && expMemWrite |-> trace.memAddr == expMemAddr)
        else reportMismatch("trace.memAddr", $sampled(expMemAddr), $sampled(trace.memAddr));

    assert property (@(posedge clk) !reset && expMemWrite |-> trace.storeData == expStoreData)
        else reportMismatch("trace.storeData", $sampled(expStoreData),
                            $sampled(trace.storeData));

    assert property (@(posedge clk) !reset && expMemWrite |-> trace.storeWidth == expStoreWidth)
        else reportMismatch("trace.storeWidth", $sampled(expStoreWidth),
                            $sampled(trace.storeWidth));

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!halted && !timedOut) begin
            @(negedge clk);
            cycles++;
            if (trace.valid) begin
                retired++;
            end
            if (trace.valid && trace.pc == haltAddr) begin
                halted = 1'b1;
            end else if (cycles >= cycleLimit) begin
                timedOut = 1'b1;
            end
        end
        // Halt loop retires twice more so its checks run
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (timedOut) begin
            $display("timeout: halt loop not reached within %0d cycles", cycleLimit);
        end
        $display("retired %0d instructions in %0d cycles, %0d errors", retired, cycles, errors);
        if (!timedOut && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mipsPkg::aluOp_t op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  logic [4:0]      shamt,
    output logic [31:0]     result,
    output logic            aZero,
    output logic            aNeg,
    output logic            aEqualsB
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {31'd0, $signed(a) < $signed(b)};
            // Shifts act on the rt side
            aluSll:   result = b << shamt;
            aluSrl:   result = b >> shamt;
            // Low word of the product
            aluMul:   result = a * b;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // Branch flags, rs against rt
    assign aZero = (a == 32'd0);
    assign aNeg = a[31];
    assign aEqualsB = (a == b);

endmodule

`default_nettype wire

//--- verilog/controller.sv
`timescale 1ns/1ns
`default_nettype none

module controller (
    input  mipsPkg::instrWord_t instr,
    output mipsPkg::control_t   ctrl
);
    import mipsPkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.branchKind = brNone;
        ctrl.memWidth = memWord;
        ctrl.aluOp = aluAdd;

        case (instr.rFields.op)
            ////////////////////////////////////////
            // R-type, jr lives here too
            ////////////////////////////////////////
            opSpecial: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.rFields.funct)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr:  ctrl.aluOp = aluOr;
                    fnXor: ctrl.aluOp = aluXor;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSll: begin
                        ctrl.aluOp = aluSll;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    fnSrl: begin
                        ctrl.aluOp = aluSrl;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg = 1'b1;
                        ctrl.branchKind = brAlways;
                        ctrl.aluOp = aluPassB;
                    end
                    // Unknown function retires as a nop
                    default: ctrl.regWrite = 1'b0;
                endcase
            end

            // Only mul is decoded under SPECIAL2
            opSpecial2: begin
                if (instr.rFields.funct == fnMul) begin
                    ctrl.regDst = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = aluMul;
                end
            end

            ////////////////////////////////////////
            // Loads and stores
            ////////////////////////////////////////
            opLw, opLh, opLb: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.extendSigned = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memWidth = (instr.iFields.op == opLw) ? memWord :
                                (instr.iFields.op == opLh) ? memHalf : memByte;
            end

            opSw, opSh, opSb: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.extendSigned = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.memWidth = (instr.iFields.op == opSw) ? memWord :
                                (instr.iFields.op == opSh) ? memHalf : memByte;
            end

            ////////////////////////////////////////
            // Branches and jumps
            ////////////////////////////////////////
            opRegimm: begin
                ctrl.extendSigned = 1'b1;
                case (instr.iFields.rt)
                    5'd0:    ctrl.branchKind = brLtz;
                    5'd1:    ctrl.branchKind = brGez;
                    default: ctrl.branchKind = brNone;
                endcase
            end

            opBeq, opBne, opBgtz, opBlez: begin
                ctrl.extendSigned = 1'b1;
                ctrl.aluOp = aluSub;
                case (instr.iFields.op)
                    opBeq:   ctrl.branchKind = brEq;
                    opBne:   ctrl.branchKind = brNe;
                    opBgtz:  ctrl.branchKind = brGtz;
                    default: ctrl.branchKind = brLez;
                endcase
            end

            opJ, opJal: begin
                ctrl.jumpAbs = 1'b1;
                ctrl.branchKind = brAlways;
                ctrl.aluOp = aluPassB;
                // Return address goes to r31
                ctrl.link = (instr.jFields.op == opJal);
                ctrl.regWrite = (instr.jFields.op == opJal);
            end

            // I-type ALU group, unknown opcodes land here as well
            default: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.iFields.op)
                    opOri: ctrl.aluOp = aluOr;
                    opXori: ctrl.aluOp = aluXor;
                    opSlti: begin
                        ctrl.aluOp = aluSlt;
                        ctrl.extendSigned = 1'b1;
                    end
                    default: begin
                        ctrl.aluOp = aluAdd;
                        ctrl.extendSigned = 1'b1;
                    end
                endcase
            end
        endcase
    end

    // A load and a store never share one instruction
    always_comb begin
        assert final (!(ctrl.memRead && ctrl.memWrite))
            else $error("controller drives memRead and memWrite together");
    end

endmodule

`default_nettype wire

//--- verilog/dataMemory.sv
`timescale 1ns/1ns
`default_nettype none

module dataMemory #(
    parameter int dataWords = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               read,
    input  logic               write,
    input  mipsPkg::memWidth_t width,
    input  logic [31:0]        addr,
    input  logic [31:0]        storeData,
    output logic [31:0]        loadData
);
    import mipsPkg::*;

    localparam int indexBits = $clog2(dataWords);

    logic [31:0]          mem [dataWords];
    logic [indexBits-1:0] wordIndex;
    logic [31:0]          word;
    logic [3:0]           laneMask;
    logic [31:0]          laneData;
    logic [15:0]          half;
    logic [7:0]           byteVal;

    // Address wraps at the top of the array
    assign wordIndex = addr[indexBits+1:2];
    assign word = mem[wordIndex];

    ////////////////////////////////////////
    // Store lanes, little endian
    ////////////////////////////////////////
    always_comb begin
        case (width)
            memHalf: begin
                laneMask = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{storeData[15:0]}};
            end
            memByte: begin
                laneMask = 4'b0001 << addr[1:0];
                laneData = {4{storeData[7:0]}};
            end
            default: begin
                laneMask = 4'b1111;
                laneData = storeData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dataWords; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneMask[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Loads, sign extended
    ////////////////////////////////////////
    assign half = addr[1] ? word[31:16] : word[15:0];
    assign byteVal = word[addr[1:0]*8 +: 8];

    always_comb begin
        if (!read) begin
            loadData = '0;
        end else begin
            case (width)
                memHalf: loadData = {{16{half[15]}}, half};
                memByte: loadData = {{24{byteVal[7]}}, byteVal};
                default: loadData = word;
            endcase
        end
    end

    // Natural alignment for half and word accesses
    assert property (@(posedge clk) disable iff (reset)
        (read || write) |->
            ((width == memWord && addr[1:0] == 2'b00) ||
             (width == memHalf && addr[0] == 1'b0) ||
             width == memByte))
        else $error("misaligned access at %h", addr);

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
    parameter logic [31:0] resetVector = 32'h0000_0000,
    parameter int          dataWords = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  mipsPkg::instrWord_t   instr,
    output logic [31:0]           instrAddr,
    output mipsPkg::retireTrace_t trace
);
    import mipsPkg::*;

    control_t    ctrl;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] immExt;
    logic [31:0] operandB;
    logic [4:0]  shiftAmount;
    logic [31:0] aluResult;
    logic        rsZero;
    logic        rsNeg;
    logic        rsEqualsRt;
    logic [31:0] loadData;
    logic [4:0]  writeReg;
    logic [31:0] writeData;
    logic        regWriteEn;
    logic        memWriteEn;

    controller ctrlDecode (
        .instr(instr),
        .ctrl (ctrl)
    );

    pcUnit #(.resetVector(resetVector)) pcLogic (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .ctrl      (ctrl),
        .rsValue   (rsData),
        .rsZero    (rsZero),
        .rsNeg     (rsNeg),
        .rsEqualsRt(rsEqualsRt),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    assign instrAddr = pc;

    ////////////////////////////////////////
    // Operands and execute
    ////////////////////////////////////////
    registerFile regs (
        .clk        (clk),
        .reset      (reset),
        .writeEnable(regWriteEn),
        .readAddrA  (instr.rFields.rs),
        .readAddrB  (instr.rFields.rt),
        .writeAddr  (writeReg),
        .writeData  (writeData),
        .readDataA  (rsData),
        .readDataB  (rtData)
    );

    // ori and xori take the immediate zero extended
    assign immExt = ctrl.extendSigned ? {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16}
                                      : {16'd0, instr.iFields.imm16};
    assign operandB = ctrl.aluSrcImm ? immExt : rtData;
    assign shiftAmount = ctrl.shiftByShamt ? instr.rFields.shamt : 5'd0;

    alu exec (
        .op      (ctrl.aluOp),
        .a       (rsData),
        .b       (operandB),
        .shamt   (shiftAmount),
        .result  (aluResult),
        .aZero   (rsZero),
        .aNeg    (rsNeg),
        .aEqualsB(rsEqualsRt)
    );

    dataMemory #(.dataWords(dataWords)) dmem (
        .clk      (clk),
        .reset    (reset),
        .read     (ctrl.memRead),
        .write    (memWriteEn),
        .width    (ctrl.memWidth),
        .addr     (aluResult),
        .storeData(rtData),
        .loadData (loadData)
    );

    ////////////////////////////////////////
    // Writeback and retire trace
    ////////////////////////////////////////
    assign regWriteEn = ctrl.regWrite && !reset;
    assign memWriteEn = ctrl.memWrite && !reset;

    assign writeReg = ctrl.link ? linkReg :
                      ctrl.regDst ? instr.rFields.rd : instr.rFields.rt;
    assign writeData = ctrl.link ? pcPlus4 :
                       ctrl.memToReg ? loadData : aluResult;

    always_comb begin
        trace.valid = !reset;
        trace.pc = pc;
        trace.regWrite = regWriteEn;
        trace.wrReg = writeReg;
        trace.wrData = writeData;
        trace.memWrite = memWriteEn;
        trace.memAddr = aluResult;
        trace.storeData = rtData;
        trace.storeWidth = ctrl.memWidth;
    end

endmodule

`default_nettype wire

//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        opSpecial  = 6'h00,
        opRegimm   = 6'h01,
        opJ        = 6'h02,
        opJal      = 6'h03,
        opBeq      = 6'h04,
        opBne      = 6'h05,
        opBlez     = 6'h06,
        opBgtz     = 6'h07,
        opAddi     = 6'h08,
        opSlti     = 6'h0a,
        opOri      = 6'h0d,
        opXori     = 6'h0e,
        opSpecial2 = 6'h1c,
        opLb       = 6'h20,
        opLh       = 6'h21,
        opLw       = 6'h23,
        opSb       = 6'h28,
        opSh       = 6'h29,
        opSw       = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2a
    } funct_t;

    // SPECIAL2 mul reuses the srl function code
    localparam funct_t fnMul = fnSrl;

    localparam logic [4:0] linkReg = 5'd31;

    typedef struct packed {
        opcode_t    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rFields_t;

    typedef struct packed {
        opcode_t     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields_t;

    typedef struct packed {
        opcode_t     op;
        logic [25:0] target26;
    } jFields_t;

    // One fetched word, three views of its fields
    typedef union packed {
        rFields_t rFields;
        iFields_t iFields;
        jFields_t jFields;
    } instrWord_t;

    ////////////////////////////////////////
    // Control and trace
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSll, aluSrl, aluMul, aluPassB
    } aluOp_t;

    typedef enum logic [1:0] {
        memWord = 2'd0,
        memHalf = 2'd1,
        memByte = 2'd2
    } memWidth_t;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brGtz, brLez, brLtz, brGez, brAlways
    } branchKind_t;

    typedef struct packed {
        logic        regDst;
        logic        aluSrcImm;
        logic        extendSigned;
        logic        shiftByShamt;
        logic        memRead;
        logic        memWrite;
        memWidth_t   memWidth;
        logic        memToReg;
        logic        regWrite;
        logic        link;
        logic        jumpReg;
        logic        jumpAbs;
        branchKind_t branchKind;
        aluOp_t      aluOp;
    } control_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  wrReg;
        logic [31:0] wrData;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] storeData;
        memWidth_t   storeWidth;
    } retireTrace_t;

endpackage

`default_nettype wire

//--- verilog/pcUnit.sv
`timescale 1ns/1ns
`default_nettype none

module pcUnit #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::instrWord_t instr,
    input  mipsPkg::control_t   ctrl,
    input  logic [31:0]         rsValue,
    input  logic                rsZero,
    input  logic                rsNeg,
    input  logic                rsEqualsRt,
    output logic [31:0]         pc,
    output logic [31:0]         pcPlus4
);
    import mipsPkg::*;

    logic        taken;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{instr.iFields.imm16[15]}}, instr.iFields.imm16, 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instr.jFields.target26, 2'b00};

    // Branch condition from the rs flags
    always_comb begin
        case (ctrl.branchKind)
            brEq:     taken = rsEqualsRt;
            brNe:     taken = !rsEqualsRt;
            brGtz:    taken = !rsNeg && !rsZero;
            brLez:    taken = rsNeg || rsZero;
            brLtz:    taken = rsNeg;
            brGez:    taken = !rsNeg;
            brAlways: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken) begin
            nextPc = pcPlus4;
        end else if (ctrl.jumpReg) begin
            nextPc = rsValue;
        end else if (ctrl.jumpAbs) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = branchTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

    // Every update keeps the fetch address on a word boundary
    assert property (@(posedge clk) !reset |=> pc[1:0] == 2'b00)
        else $error("pc left word alignment: %h", pc);

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic        writeEnable,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    // r0 is stored like the rest and only ever cleared
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // Writes aimed at r0 must never land
    assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0)
        else $error("r0 holds a nonzero value");

endmodule

`default_nettype wire
